// ==== adc_config_pkg.sv ====
// adc configuration shared definitions
package adc_config_pkg;

  localparam int adc_addr_w  = 8;   // register address bits
  localparam int adc_data_w  = 16;  // register data bits
  localparam int adc_frame_w = adc_addr_w + adc_data_w;  // address first, then data

  // config register hit by the power-up write
  localparam logic [adc_addr_w-1:0] adc_auto_addr = 8'h81;

  // operating modes, encoding 0 to 6
  typedef enum logic [2:0] {
    achan_dmux1   = 3'd0,  // one channel on A input
    achan_dmux2   = 3'd1,
    cchan_dmux1   = 3'd2,  // one channel on C input
    cchan_dmux2   = 3'd3,
    twochan_dmux1 = 3'd4,  // both channels
    twochan_dmux2 = 3'd5,
    test_ramp     = 3'd6   // internal ramp pattern
  } adc_mode_e;

  // config register contents per mode
  // bit 6 selects demux 1:1 against 1:2, bits 3:1 pick the channel setup
  function automatic logic [adc_data_w-1:0] adc_mode_word(input adc_mode_e mode);
    logic [adc_data_w-1:0] word;
    case (mode)
      achan_dmux1:   word = 16'h03c8;
      achan_dmux2:   word = 16'h0388;
      cchan_dmux1:   word = 16'h03ca;
      cchan_dmux2:   word = 16'h038a;
      twochan_dmux1: word = 16'h03c4;
      twochan_dmux2: word = 16'h0384;
      test_ramp:     word = 16'h13c4;  // ramp enable on top of two-channel 1:1
      default:       word = 16'h03c8;  // fall back to A channel 1:1
    endcase
    return word;
  endfunction

endpackage

// ==== adc_cfg_if.sv ====
// register write request channel
interface adc_cfg_if;

  logic                                   start;  // one-cycle strobe
  logic [adc_config_pkg::adc_addr_w-1:0]  addr;   // valid with start
  logic [adc_config_pkg::adc_data_w-1:0]  data;   // valid with start
  logic                                   busy;   // engine shifting a frame

  // source of write requests
  modport requester (
    output start,
    output addr,
    output data,
    input  busy
  );

  // serial engine side, strobes taken only while busy is low
  modport engine (
    input  start,
    input  addr,
    input  data,
    output busy
  );

endinterface

// ==== adc_serial_shifter.sv ====
// three-wire serial engine
// one 24-bit frame per accepted strobe, msb first
module adc_serial_shifter #(
  parameter int CLK_DIV_LOG2 = 7  // bit period is 2**CLK_DIV_LOG2 clk cycles
) (
  input  logic      clk,
  input  logic      rst,
  adc_cfg_if.engine req,
  output logic      sclk_o,       // serial clock
  output logic      sdata_o,      // serial data
  output logic      sen_n_o,      // serial enable, active low
  output logic      spi_rst_n_o   // serial port reset pulse before each frame
);

  localparam int FRAME_W = adc_config_pkg::adc_frame_w;
  localparam int CNT_W   = $clog2(FRAME_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_W - 1);

  typedef enum logic [2:0] {
    st_idle,    // nothing to send
    st_wait,    // line up with the next tick, port reset held low
    st_strb0,   // one quiet period with enable high
    st_data,    // FRAME_W periods of data
    st_commit,  // commit period after the last bit
    st_strb1,   // enable high again
    st_swait    // guard period before the next frame
  } xfer_state_e;

  xfer_state_e             st_q;
  logic [CLK_DIV_LOG2-1:0] div_q;    // free-running bit divider
  logic [CNT_W-1:0]        bit_q;    // data bits already shifted
  logic [FRAME_W-1:0]      shift_q;  // outgoing frame, msb on the line
  logic                    tick;
  logic                    accept;
  logic                    shift_en;

  assign tick     = &div_q;                         // divider about to wrap
  assign accept   = req.start && (st_q == st_idle);  // strobes while busy are ignored
  assign shift_en = tick && (st_q == st_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;  // wraps on its own
    end
  end

  // frame state machine, advances on ticks only
  always_ff @(posedge clk) begin
    if (rst) begin
      st_q  <= st_idle;
      bit_q <= '0;
    end else if (accept) begin
      st_q  <= st_wait;
      bit_q <= '0;
    end else if (tick) begin
      case (st_q)
        st_wait:   st_q <= st_strb0;
        st_strb0:  st_q <= st_data;
        st_data: begin
          bit_q <= bit_q + 1'b1;
          if (bit_q == LAST_BIT) begin
            st_q <= st_commit;  // all bits out
          end
        end
        st_commit: st_q <= st_strb1;
        st_strb1:  st_q <= st_swait;
        st_swait:  st_q <= st_idle;
        default:   st_q <= st_idle;  // idle stays idle
      endcase
    end
  end

  // payload, loaded on accept and shifted left each data tick
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= {req.addr, req.data};
    end else if (shift_en) begin
      shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
    end
  end

  assign req.busy = (st_q != st_idle);  // rises the cycle after accept

  // low half then high half of each period, receiver samples on the rise
  assign sclk_o      = (st_q == st_idle || st_q == st_wait) ? 1'b0 : div_q[CLK_DIV_LOG2-1];
  assign sdata_o     = shift_q[FRAME_W-1];
  assign sen_n_o     = (st_q != st_data);
  assign spi_rst_n_o = (st_q != st_wait);   // shorter than one bit period

  a_no_enable_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    !req.busy |-> sen_n_o
  ) else $error("sen_n_o low while engine idle");

  // a late strobe must not disturb the frame on the line
  a_busy_strobe_keeps_frame: assert property (
    @(posedge clk) disable iff (rst)
    (req.start && req.busy && !shift_en) |=> $stable(shift_q)
  ) else $error("strobe during busy changed the shift register");

endmodule

// ==== adc_auto_config.sv ====
// power-up configuration sequencer
module adc_auto_config #(
  parameter int                        CLEAR_WAIT = 1023,  // mode line settle cycles
  parameter adc_config_pkg::adc_mode_e MODE       = adc_config_pkg::achan_dmux1
) (
  input  logic         clk,
  input  logic         rst,
  adc_cfg_if.requester req,
  output logic         ddrb_o,       // adc reset pulse
  output logic         dcm_reset_o,  // held until the sequence is done
  output logic         mode_pin_o,   // adc serial mode line
  output logic         cfg_done_o
);

  localparam int WAIT_W = $clog2(CLEAR_WAIT + 1);
  localparam logic [WAIT_W-1:0] WAIT_INIT = WAIT_W'(CLEAR_WAIT);
  localparam logic [WAIT_W-1:0] WAIT_HALF = WAIT_W'(CLEAR_WAIT / 2);

  typedef enum logic [2:0] {
    st_clear,  // settle wait, mode line heavily loaded
    st_set,
    st_load,   // strobe the auto write
    st_busy,   // frame on the line
    st_ddrb,   // one-cycle adc reset
    st_done
  } conf_state_e;

  conf_state_e       st_q;
  logic [WAIT_W-1:0] wait_q;        // settle countdown
  logic              strobe_seen_q; // auto write issued since reset

  always_ff @(posedge clk) begin
    if (rst) begin
      st_q   <= st_clear;
      wait_q <= WAIT_INIT;
    end else begin
      case (st_q)
        st_clear: begin
          if (wait_q == '0) begin
            st_q <= st_set;
          end else begin
            wait_q <= wait_q - 1'b1;
          end
        end
        st_set:  st_q <= st_load;
        st_load: st_q <= st_busy;  // engine idle here, strobe is taken
        st_busy: begin
          if (!req.busy) begin
            st_q <= st_ddrb;  // frame complete
          end
        end
        st_ddrb: st_q <= st_done;
        default: st_q <= st_done;  // stays done until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_seen_q <= 1'b0;
    end else if (req.start) begin
      strobe_seen_q <= 1'b1;
    end
  end

  assign req.start = (st_q == st_load);
  assign req.addr  = adc_config_pkg::adc_auto_addr;
  assign req.data  = adc_config_pkg::adc_mode_word(MODE);

  assign mode_pin_o  = (wait_q < WAIT_HALF);  // high in the second half of the wait
  assign ddrb_o      = (st_q == st_ddrb);
  assign dcm_reset_o = (st_q != st_done);
  assign cfg_done_o  = (st_q == st_done);

  // exactly one auto write per reset, and it comes before done
  a_single_strobe: assert property (
    @(posedge clk) disable iff (rst)
    req.start |-> !strobe_seen_q
  ) else $error("auto sequencer strobed twice");

  a_strobe_before_done: assert property (
    @(posedge clk) disable iff (rst)
    cfg_done_o |-> strobe_seen_q
  ) else $error("config done without an auto write");

endmodule

// ==== adc_config_arbiter.sv ====
// write source select, auto or host
module adc_config_arbiter (
  input  logic                                  clk,
  input  logic                                  rst,
  adc_cfg_if.engine                             auto_req,  // from the sequencer
  adc_cfg_if.requester                          eng_req,   // to the serial engine
  input  logic                                  cfg_done_i,
  input  logic                                  host_start_i,
  input  logic [adc_config_pkg::adc_addr_w-1:0] host_addr_i,
  input  logic [adc_config_pkg::adc_data_w-1:0] host_data_i,
  output logic                                  drop_o     // host strobe lost
);

  logic host_ok;  // host may start a frame this cycle
  logic drop_q;

  assign host_ok = cfg_done_i && !eng_req.busy;

  // sequencer owns the engine until done, host after that
  assign eng_req.start = cfg_done_i ? (host_start_i && !eng_req.busy) : auto_req.start;
  assign eng_req.addr  = cfg_done_i ? host_addr_i : auto_req.addr;
  assign eng_req.data  = cfg_done_i ? host_data_i : auto_req.data;

  assign auto_req.busy = eng_req.busy;  // sequencer waits on the real engine state

  // no back-pressure, a refused host strobe is only reported
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_q <= 1'b0;
    end else begin
      drop_q <= host_start_i && !host_ok;
    end
  end

  assign drop_o = drop_q;

  // a forwarded strobe finds the engine idle and gets accepted
  a_forward_accepted: assert property (
    @(posedge clk) disable iff (rst)
    eng_req.start |-> !eng_req.busy ##1 eng_req.busy
  ) else $error("strobe forwarded to a busy engine");

endmodule

// ==== adc_config_top.sv ====
// adc configuration block top
module adc_config_top #(
  parameter int                        CLK_DIV_LOG2 = 7,     // serial bit period exponent
  parameter int                        CLEAR_WAIT   = 1023,  // mode line settle cycles
  parameter adc_config_pkg::adc_mode_e MODE         = adc_config_pkg::achan_dmux1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  host_start_i,
  input  logic [adc_config_pkg::adc_addr_w-1:0] host_addr_i,
  input  logic [adc_config_pkg::adc_data_w-1:0] host_data_i,
  output logic                                  busy_o,
  output logic                                  drop_o,
  output logic                                  sclk_o,
  output logic                                  sdata_o,
  output logic                                  sen_n_o,
  output logic                                  spi_rst_n_o,
  output logic                                  ddrb_o,
  output logic                                  dcm_reset_o,
  output logic                                  mode_pin_o,
  output logic                                  cfg_done_o
);

  adc_cfg_if auto_req ();  // sequencer to arbiter
  adc_cfg_if eng_req ();   // arbiter to serial engine

  adc_auto_config #(
    .CLEAR_WAIT (CLEAR_WAIT),
    .MODE       (MODE)
  ) u_auto (
    .clk         (clk),
    .rst         (rst),
    .req         (auto_req.requester),
    .ddrb_o      (ddrb_o),
    .dcm_reset_o (dcm_reset_o),
    .mode_pin_o  (mode_pin_o),
    .cfg_done_o  (cfg_done_o)
  );

  adc_config_arbiter u_arb (
    .clk          (clk),
    .rst          (rst),
    .auto_req     (auto_req.engine),
    .eng_req      (eng_req.requester),
    .cfg_done_i   (cfg_done_o),
    .host_start_i (host_start_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .drop_o       (drop_o)
  );

  adc_serial_shifter #(
    .CLK_DIV_LOG2 (CLK_DIV_LOG2)
  ) u_shift (
    .clk         (clk),
    .rst         (rst),
    .req         (eng_req.engine),
    .sclk_o      (sclk_o),
    .sdata_o     (sdata_o),
    .sen_n_o     (sen_n_o),
    .spi_rst_n_o (spi_rst_n_o)
  );

  assign busy_o = eng_req.busy;  // engine state as seen by the host

endmodule

// ==== tb_adc_config.sv ====
// adc configuration block testbench
module tb_adc_config;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_DIV_LOG2 = 3;
  localparam int CLEAR_WAIT   = 40;
  localparam int BIT_CYC      = 1 << CLK_DIV_LOG2;  // clk cycles per serial bit
  localparam int RESET_CYC    = 10;
  localparam int CLK_PERIOD   = 100;
  localparam int N_ENTRIES    = 6;
  localparam int FRAME_W      = adc_config_pkg::adc_frame_w;
  localparam int WATCHDOG_CYC = (N_ENTRIES + 2) * 40 * BIT_CYC + CLEAR_WAIT + RESET_CYC;

  typedef struct packed {
    logic                                  b2b;   // sent right behind the previous entry
    logic [adc_config_pkg::adc_addr_w-1:0] addr;
    logic [adc_config_pkg::adc_data_w-1:0] data;
  } stim_t;

  logic                                  clk;
  logic                                  rst;
  logic                                  host_start_i;
  logic [adc_config_pkg::adc_addr_w-1:0] host_addr_i;
  logic [adc_config_pkg::adc_data_w-1:0] host_data_i;
  logic                                  busy_o;
  logic                                  drop_o;
  logic                                  sclk_o;
  logic                                  sdata_o;
  logic                                  sen_n_o;
  logic                                  spi_rst_n_o;
  logic                                  ddrb_o;
  logic                                  dcm_reset_o;
  logic                                  mode_pin_o;
  logic                                  cfg_done_o;

  stim_t              stim [N_ENTRIES];
  logic [FRAME_W-1:0] frame_q [$];  // frames seen on the serial line
  logic [FRAME_W-1:0] shift_in;
  int bit_cnt     = 0;
  int frames_seen = 0;
  int rst_pulses  = 0;
  int rst_len     = 0;
  int line_err    = 0;
  int err_cnt     = 0;
  int pass_cnt    = 0;
  int fail_cnt    = 0;

  adc_config_top #(
    .CLK_DIV_LOG2 (CLK_DIV_LOG2),
    .CLEAR_WAIT   (CLEAR_WAIT),
    .MODE         (adc_config_pkg::twochan_dmux2)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .host_start_i (host_start_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .busy_o       (busy_o),
    .drop_o       (drop_o),
    .sclk_o       (sclk_o),
    .sdata_o      (sdata_o),
    .sen_n_o      (sen_n_o),
    .spi_rst_n_o  (spi_rst_n_o),
    .ddrb_o       (ddrb_o),
    .dcm_reset_o  (dcm_reset_o),
    .mode_pin_o   (mode_pin_o),
    .cfg_done_o   (cfg_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // serial receiver takes msb first on the rising serial clock
  always @(posedge sclk_o) begin
    if (sen_n_o === 1'b0) begin
      shift_in = {shift_in[FRAME_W-2:0], sdata_o};
      bit_cnt++;
      if (bit_cnt == FRAME_W) begin
        frame_q.push_back(shift_in);
        frames_seen++;
        bit_cnt = 0;
      end
    end
  end

  always @(posedge sen_n_o) begin
    if (bit_cnt != 0) begin
      $display("serial frame cut short after %0d bits", bit_cnt);
      line_err++;
      bit_cnt = 0;
    end
  end

  // idle line level and port reset pulses sampled mid cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (busy_o === 1'b0 && (sclk_o !== 1'b0 || sen_n_o !== 1'b1)) begin
        if (line_err == 0) $display("serial line active while the engine is idle");
        line_err++;
      end
      if (spi_rst_n_o === 1'b0) begin
        if (rst_len == 0) rst_pulses++;  // new pulse
        rst_len++;
        if (rst_len == BIT_CYC + 1) begin
          $display("serial port reset held longer than one bit period");
          line_err++;
        end
      end else begin
        rst_len = 0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("watchdog expired, run exceeded %0d clock cycles", WATCHDOG_CYC);
    $display("Verification failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("ERROR %s expected %h got %h", name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int errs);
    if (errs == 0) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d error(s)", name, errs);
    end
  endtask

  // one-cycle host strobe with drop_o answering a cycle later
  task automatic host_write(input stim_t s, input logic exp_drop);
    @(posedge clk);
    #5;
    host_start_i = 1'b1;
    host_addr_i  = s.addr;
    host_data_i  = s.data;
    @(posedge clk);
    #5;
    host_start_i = 1'b0;
    @(negedge clk);
    check_val("drop_o", {31'd0, exp_drop}, drop_o);
    if (!exp_drop) check_val("busy_o", 1, busy_o);
    @(negedge clk);
    check_val("drop_o", 0, drop_o);  // single-cycle pulse
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (busy_o !== 1'b0 && n < 40 * BIT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (busy_o !== 1'b0) begin
      $display("timed out waiting for the end of %s", what);
      err_cnt++;
    end
  endtask

  task automatic check_frame(input string name, input logic [FRAME_W-1:0] exp_frame);
    logic [FRAME_W-1:0] got;
    wait_idle(name);
    @(negedge clk);
    if (frame_q.size() == 0) begin
      $display("no serial frame received for %s", name);
      err_cnt++;
    end else begin
      got = frame_q.pop_front();
      check_val({name, " frame"}, exp_frame, got);
    end
  endtask

  initial begin
    int errs;
    int n;
    int gap;
    int pending;
    int pend_errs;
    int exp_frames;
    logic [FRAME_W-1:0] auto_frame;
    void'($urandom(32'h04c7_7b3e));
    // b2b entries land on a busy engine and are dropped
    stim[0] = {1'b0, 8'h01, 16'h0abc};
    stim[1] = {1'b0, 8'h82, 16'h5a5a};
    stim[2] = {1'b1, 8'h83, 16'hffff};
    stim[3] = {1'b0, 8'h84, 16'h0001};
    stim[4] = {1'b0, 8'h90, 16'h8000};
    stim[5] = {1'b1, 8'h3c, 16'h1234};
    auto_frame = {adc_config_pkg::adc_auto_addr,
                  adc_config_pkg::adc_mode_word(adc_config_pkg::twochan_dmux2)};
    rst          = 1'b1;
    host_start_i = 1'b0;
    host_addr_i  = '0;
    host_data_i  = '0;
    exp_frames   = 1;  // auto write
    pending      = 0;
    pend_errs    = 0;
    repeat (RESET_CYC) @(posedge clk);
    #5;
    rst = 1'b0;

    errs = err_cnt;  // sequencer still settling
    repeat (4) @(posedge clk);
    host_write({1'b0, 8'h55, 16'haaaa}, 1'b1);
    check_val("busy_o", 0, busy_o);
    check_val("cfg_done_o", 0, cfg_done_o);
    check_val("mode_pin_o", 0, mode_pin_o);  // first half of the settle wait
    report("host strobe before config done", err_cnt - errs);

    errs = err_cnt;
    n = 0;
    while (busy_o !== 1'b1 && n < CLEAR_WAIT + 4 * BIT_CYC) begin
      if (n == CLEAR_WAIT / 2) begin
        check_val("mode_pin_o", 1, mode_pin_o);  // well into the second half
      end
      @(negedge clk);
      n++;
    end
    if (busy_o !== 1'b1) begin
      $display("auto write never started");
      err_cnt++;
    end
    n = 0;
    while (busy_o === 1'b1 && n < 40 * BIT_CYC) begin
      check_val("dcm_reset_o", 1, dcm_reset_o);
      check_val("cfg_done_o", 0, cfg_done_o);
      check_val("ddrb_o", 0, ddrb_o);
      @(negedge clk);
      n++;
    end
    check_frame("auto write", auto_frame);
    report("auto write frame", err_cnt - errs);

    errs = err_cnt;
    n = 0;
    while (ddrb_o !== 1'b1 && n < 4) begin
      @(negedge clk);
      n++;
    end
    check_val("ddrb_o", 1, ddrb_o);
    check_val("dcm_reset_o", 1, dcm_reset_o);
    check_val("cfg_done_o", 0, cfg_done_o);
    @(negedge clk);
    check_val("ddrb_o", 0, ddrb_o);  // one cycle only
    check_val("cfg_done_o", 1, cfg_done_o);
    check_val("dcm_reset_o", 0, dcm_reset_o);
    report("ddrb pulse and dcm release", err_cnt - errs);

    for (int i = 0; i < N_ENTRIES; i++) begin
      errs = err_cnt;
      if (stim[i].b2b) begin
        host_write(stim[i], 1'b1);
        n = err_cnt - errs;
        errs = err_cnt;
        // frame already on the line must come out unchanged
        check_frame($sformatf("entry %0d", pending), {stim[pending].addr, stim[pending].data});
        report($sformatf("entry %0d", pending), pend_errs + err_cnt - errs);
        report($sformatf("entry %0d dropped while busy", i), n);
      end else begin
        wait_idle("previous frame");
        gap = $urandom % 8;  // random idle gap
        repeat (gap) @(posedge clk);
        host_write(stim[i], 1'b0);
        exp_frames++;
        if (i + 1 < N_ENTRIES && stim[i + 1].b2b) begin
          pending   = i;
          pend_errs = err_cnt - errs;
        end else begin
          check_frame($sformatf("entry %0d", i), {stim[i].addr, stim[i].data});
          report($sformatf("entry %0d", i), err_cnt - errs);
        end
      end
    end

    errs = err_cnt;
    repeat (2 * BIT_CYC) @(negedge clk);
    check_val("frames received", exp_frames, frames_seen);
    check_val("frames unclaimed", 0, frame_q.size());
    check_val("spi_rst_n_o pulses", exp_frames, rst_pulses);
    check_val("idle line violations", 0, line_err);
    report("serial line between frames", err_cnt - errs);
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
adc_config_pkg.sv
adc_cfg_if.sv
adc_serial_shifter.sv
adc_auto_config.sv
adc_config_arbiter.sv
adc_config_top.sv
tb_adc_config.sv

// ==== Bender.yml ====
package:
  name: adc_config

sources:
  - files:
      - adc_config_pkg.sv
      - adc_cfg_if.sv
      - adc_serial_shifter.sv
      - adc_auto_config.sv
      - adc_config_arbiter.sv
      - adc_config_top.sv
  - target: test
    files:
      - tb_adc_config.sv
